// ==== rtl/scalar_access_defines.svh ====
`ifndef SCALAR_ACCESS_DEFINES_SVH
`define SCALAR_ACCESS_DEFINES_SVH

// line store geometry
`define LINE_WIDTH 256
`define LINE_COUNT 4
`define LINE_SEL_WIDTH 2

// byte offset within one line, 32 bytes
`define OFFSET_WIDTH 5

// widest scalar, also the read and write data ports
`define SCALAR_WIDTH 64

// command word, from the top bit down:
// is_write, line_sel, data_type, int_size, offset
`define CMD_WIDTH 12

`endif

// ==== rtl/scalar_cpu_pkg.sv ====
package scalar_cpu_pkg;

	// how the bits of a scalar are interpreted
	typedef enum logic [1:0]
	{
		unsgn_int = 2'd0,
		sgn_int = 2'd1,
		bfloat16 = 2'd2,
		reserved = 2'd3
	} data_type_t;

	// integer width, encoded as log2 of the byte count
	typedef enum logic [1:0]
	{
		size_8 = 2'd0,
		size_16 = 2'd1,
		size_32 = 2'd2,
		size_64 = 2'd3
	} int_size_t;

endpackage

// ==== rtl/scalar_shifter_pkg.sv ====
`include "scalar_access_defines.svh"

package scalar_shifter_pkg;

	import scalar_cpu_pkg::*;

	typedef struct packed
	{
		logic [`LINE_WIDTH-1:0] to_shift;
		data_type_t data_type;
		int_size_t int_size;
		logic [`OFFSET_WIDTH-1:0] offset;
	} read_shift_in_t;

	// selected lane in the low bits, upper bits zero
	typedef struct packed
	{
		logic [`SCALAR_WIDTH-1:0] data;
	} read_shift_out_t;

	typedef struct packed
	{
		logic [`LINE_WIDTH-1:0] to_modify;
		logic [`SCALAR_WIDTH-1:0] to_shift;
		data_type_t data_type;
		int_size_t int_size;
		logic [`OFFSET_WIDTH-1:0] offset;
	} write_shift_in_t;

	typedef struct packed
	{
		logic [`LINE_WIDTH-1:0] data;
	} write_shift_out_t;

	// log2 of the lane size in bytes; bfloat16 is always two bytes
	function automatic logic [1:0] lane_size_log2(data_type_t dt, int_size_t sz);
		return (dt == bfloat16) ? 2'd1 : sz;
	endfunction

	function automatic logic [`SCALAR_WIDTH-1:0] lane_mask(logic [1:0] size_log2);
		logic [`SCALAR_WIDTH-1:0] mask;
		case (size_log2)
		2'd0: mask = `SCALAR_WIDTH'(8'hff);
		2'd1: mask = `SCALAR_WIDTH'(16'hffff);
		2'd2: mask = `SCALAR_WIDTH'(32'hffff_ffff);
		default: mask = '1;
		endcase
		return mask;
	endfunction

endpackage

// ==== rtl/scalar_stage_if.sv ====
`timescale 1ns/100ps
`include "scalar_access_defines.svh"

// decoded command, decode to execute
interface scalar_cmd_if import scalar_cpu_pkg::*; ();
	logic valid;
	logic is_write;
	logic [`LINE_SEL_WIDTH-1:0] line_sel;
	data_type_t data_type;
	int_size_t int_size;
	logic [`OFFSET_WIDTH-1:0] offset;
	logic [`SCALAR_WIDTH-1:0] wr_data;

	modport decode (output valid, is_write, line_sel, data_type, int_size, offset, wr_data);
	modport execute (input valid, is_write, line_sel, data_type, int_size, offset, wr_data);
endinterface

// extracted lane, execute to result; valid only for reads
interface scalar_res_if import scalar_cpu_pkg::*; ();
	logic valid;
	logic [`SCALAR_WIDTH-1:0] data;
	data_type_t data_type;
	int_size_t int_size;

	modport execute (output valid, data, data_type, int_size);
	modport result (input valid, data, data_type, int_size);
endinterface

// ==== rtl/scalar_decode.sv ====
`timescale 1ns/100ps
`include "scalar_access_defines.svh"

module scalar_decode
	import scalar_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input logic [`CMD_WIDTH-1:0] cmd_word,
	input logic [`SCALAR_WIDTH-1:0] wr_data,
	scalar_cmd_if.decode cmd
);

	// field positions, offset in the low bits
	localparam int offset_lsb = 0;
	localparam int int_size_lsb = offset_lsb + `OFFSET_WIDTH;
	localparam int data_type_lsb = int_size_lsb + $bits(int_size_t);
	localparam int line_sel_lsb = data_type_lsb + $bits(data_type_t);
	localparam int is_write_bit = line_sel_lsb + `LINE_SEL_WIDTH;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cmd.valid <= 1'b0;
		end
		else
		begin
			cmd.valid <= cmd_valid;
		end
	end

	// payload only moves with a valid command
	always_ff @(posedge clk)
	begin
		if (cmd_valid)
		begin
			cmd.is_write <= cmd_word[is_write_bit];
			cmd.line_sel <= cmd_word[line_sel_lsb +: `LINE_SEL_WIDTH];
			cmd.data_type <= data_type_t'(cmd_word[data_type_lsb +: $bits(data_type_t)]);
			cmd.int_size <= int_size_t'(cmd_word[int_size_lsb +: $bits(int_size_t)]);
			cmd.offset <= cmd_word[offset_lsb +: `OFFSET_WIDTH];
			cmd.wr_data <= wr_data;
		end
	end

endmodule

// ==== rtl/scalar_data_shifter.sv ====
`timescale 1ns/100ps
`include "scalar_access_defines.svh"

// pulls one lane out of a line, no casting here
module scalar_read_shifter
	import scalar_cpu_pkg::*, scalar_shifter_pkg::*;
(
	input read_shift_in_t in,
	output read_shift_out_t out
);

	logic [1:0] size_log2;
	logic [`OFFSET_WIDTH-1:0] lane_base;
	logic [`OFFSET_WIDTH+2:0] bit_pos;
	logic [`LINE_WIDTH-1:0] shifted;

	always_comb
	begin
		size_log2 = lane_size_log2(in.data_type, in.int_size);
		// drop offset bits below the lane size
		lane_base = (in.offset >> size_log2) << size_log2;
		bit_pos = {lane_base, 3'b000};
		shifted = in.to_shift >> bit_pos;
	end

	always_comb
	begin
		if (in.data_type == reserved)
		begin
			out.data = '0;
		end
		else
		begin
			out.data = shifted[`SCALAR_WIDTH-1:0] & lane_mask(size_log2);
		end
	end

endmodule

// replaces one lane of a line with the low bits of a scalar
module scalar_write_shifter
	import scalar_cpu_pkg::*, scalar_shifter_pkg::*;
(
	input write_shift_in_t in,
	output write_shift_out_t out
);

	logic [1:0] size_log2;
	logic [`OFFSET_WIDTH-1:0] lane_base;
	logic [`OFFSET_WIDTH+2:0] bit_pos;
	logic [`SCALAR_WIDTH-1:0] mask;
	logic [`LINE_WIDTH-1:0] clear_bits;
	logic [`LINE_WIDTH-1:0] set_bits;

	always_comb
	begin
		size_log2 = lane_size_log2(in.data_type, in.int_size);
		lane_base = (in.offset >> size_log2) << size_log2;
		bit_pos = {lane_base, 3'b000};
		mask = lane_mask(size_log2);
		clear_bits = `LINE_WIDTH'(mask) << bit_pos;
		set_bits = `LINE_WIDTH'(in.to_shift & mask) << bit_pos;
	end

	always_comb
	begin
		// reserved wipes the whole line
		if (in.data_type == reserved)
		begin
			out.data = '0;
		end
		else
		begin
			out.data = (in.to_modify & ~clear_bits) | set_bits;
		end
	end

endmodule

// ==== rtl/scalar_execute.sv ====
`timescale 1ns/100ps
`include "scalar_access_defines.svh"

module scalar_execute
	import scalar_shifter_pkg::*;
(
	input logic clk,
	input logic rst_n,
	scalar_cmd_if.execute cmd,
	scalar_res_if.execute res
);

	logic [`LINE_WIDTH-1:0] lines [`LINE_COUNT];
	logic [`LINE_WIDTH-1:0] cur_line;
	read_shift_in_t rd_in;
	read_shift_out_t rd_out;
	write_shift_in_t wr_in;
	write_shift_out_t wr_out;

	assign cur_line = lines[cmd.line_sel];

	// same line goes to both shifters
	always_comb
	begin
		rd_in.to_shift = cur_line;
		rd_in.data_type = cmd.data_type;
		rd_in.int_size = cmd.int_size;
		rd_in.offset = cmd.offset;

		wr_in.to_modify = cur_line;
		wr_in.to_shift = cmd.wr_data;
		wr_in.data_type = cmd.data_type;
		wr_in.int_size = cmd.int_size;
		wr_in.offset = cmd.offset;
	end

	scalar_read_shifter u_read_shifter
	(
		.in(rd_in),
		.out(rd_out)
	);

	scalar_write_shifter u_write_shifter
	(
		.in(wr_in),
		.out(wr_out)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `LINE_COUNT; i++)
			begin
				lines[i] <= '0;
			end
		end
		else if (cmd.valid && cmd.is_write)
		begin
			lines[cmd.line_sel] <= wr_out.data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			res.valid <= 1'b0;
		end
		else
		begin
			res.valid <= cmd.valid && !cmd.is_write;
		end
	end

	// type and size ride along for the cast stage
	always_ff @(posedge clk)
	begin
		if (cmd.valid && !cmd.is_write)
		begin
			res.data <= rd_out.data;
			res.data_type <= cmd.data_type;
			res.int_size <= cmd.int_size;
		end
	end

endmodule

// ==== rtl/scalar_result.sv ====
`timescale 1ns/100ps
`include "scalar_access_defines.svh"

module scalar_result
	import scalar_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	scalar_res_if.result res,
	output logic rd_valid,
	output logic [`SCALAR_WIDTH-1:0] rd_data
);

	logic [`SCALAR_WIDTH-1:0] cast_data;

	always_comb
	begin
		case (res.data_type)
		sgn_int:
		begin
			case (res.int_size)
			size_8: cast_data = {{(`SCALAR_WIDTH-8){res.data[7]}}, res.data[7:0]};
			size_16: cast_data = {{(`SCALAR_WIDTH-16){res.data[15]}}, res.data[15:0]};
			size_32: cast_data = {{(`SCALAR_WIDTH-32){res.data[31]}}, res.data[31:0]};
			default: cast_data = res.data;
			endcase
		end

		unsgn_int:
		begin
			case (res.int_size)
			size_8: cast_data = {{(`SCALAR_WIDTH-8){1'b0}}, res.data[7:0]};
			size_16: cast_data = {{(`SCALAR_WIDTH-16){1'b0}}, res.data[15:0]};
			size_32: cast_data = {{(`SCALAR_WIDTH-32){1'b0}}, res.data[31:0]};
			default: cast_data = res.data;
			endcase
		end

		// raw bit pattern, zero above
		bfloat16: cast_data = {{(`SCALAR_WIDTH-16){1'b0}}, res.data[15:0]};

		default: cast_data = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= res.valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (res.valid)
		begin
			rd_data <= cast_data;
		end
	end

endmodule

// ==== rtl/scalar_access_top.sv ====
`timescale 1ns/100ps
`include "scalar_access_defines.svh"

module scalar_access_top
(
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input logic [`CMD_WIDTH-1:0] cmd_word,
	input logic [`SCALAR_WIDTH-1:0] wr_data,
	output logic rd_valid,
	output logic [`SCALAR_WIDTH-1:0] rd_data
);

	scalar_cmd_if cmd_bus ();
	scalar_res_if res_bus ();

	// command register and field split
	scalar_decode u_decode
	(
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_word(cmd_word),
		.wr_data(wr_data),
		.cmd(cmd_bus)
	);

	// line store and shifters
	scalar_execute u_execute
	(
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd_bus),
		.res(res_bus)
	);

	// cast to 64 bits and output register
	scalar_result u_result
	(
		.clk(clk),
		.rst_n(rst_n),
		.res(res_bus),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

endmodule

// ==== bench/scalar_access_assertions.sv ====
`timescale 1ns/100ps
`include "scalar_access_defines.svh"

module scalar_access_assertions
(
	input logic clk,
	input logic rst_n,
	input logic cmd_valid,
	input logic [`CMD_WIDTH-1:0] cmd_word,
	input logic rd_valid
);

	logic read_cmd;

	assign read_cmd = cmd_valid && !cmd_word[`CMD_WIDTH-1];

	// quiet through reset and one cycle past it
	reset_quiet: assert property (@(posedge clk) !rst_n |=> !rd_valid)
		else $error("rd_valid high during or right after reset");

	read_latency: assert property (@(posedge clk) disable iff (!rst_n)
		read_cmd |-> ##3 rd_valid)
		else $error("read command without rd_valid three cycles later");

	no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> $past(read_cmd, 3))
		else $error("rd_valid without a read command three cycles earlier");

endmodule

bind scalar_access_top scalar_access_assertions u_assertions
(
	.clk(clk),
	.rst_n(rst_n),
	.cmd_valid(cmd_valid),
	.cmd_word(cmd_word),
	.rd_valid(rd_valid)
);

// ==== bench/scalar_access_checker.sv ====
`timescale 1ns/100ps
`include "scalar_access_defines.svh"

module scalar_access_checker
	import scalar_cpu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [2:0] test_id,
	input logic cmd_valid,
	input logic [`CMD_WIDTH-1:0] cmd_word,
	input logic [`SCALAR_WIDTH-1:0] wr_data,
	input logic rd_valid,
	input logic [`SCALAR_WIDTH-1:0] rd_data,
	output int mismatch_count,
	output int protocol_count,
	output int pending
);

	string names [7] = '{"reset_reads", "write_read", "neighbors", "sign_ext",
		"reserved", "back_to_back", "random_mix"};
	logic [`LINE_WIDTH-1:0] model [`LINE_COUNT];
	logic [`SCALAR_WIDTH-1:0] expect_q [$];
	int cycle_q [$];
	int test_q [$];
	int cycle;
	logic [`SCALAR_WIDTH-1:0] exp_data;
	int exp_cycle;
	int exp_test;

	// lane width in bits, bfloat16 always 16
	function automatic int lane_bits(logic [1:0] dt, logic [1:0] sz);
		if (dt == bfloat16)
			return 16;
		return 8 << sz;
	endfunction

	function automatic logic [`SCALAR_WIDTH-1:0] low_mask(int bits);
		if (bits >= 64)
			return '1;
		return (64'd1 << bits) - 64'd1;
	endfunction

	// lane pick plus cast to 64 bits
	function automatic logic [`SCALAR_WIDTH-1:0] predict(logic [`LINE_WIDTH-1:0] line,
		logic [1:0] dt, logic [1:0] sz, logic [4:0] off);
		int bits;
		int pos;
		logic [`SCALAR_WIDTH-1:0] lane;
		bits = lane_bits(dt, sz);
		pos = (int'(off) / (bits / 8)) * bits;
		lane = 64'(line >> pos) & low_mask(bits);
		if (dt == reserved)
			return '0;
		if (dt == sgn_int && ((lane >> (bits - 1)) & 64'd1) != 0)
			lane = lane | ~low_mask(bits);
		return lane;
	endfunction

	function automatic logic [`LINE_WIDTH-1:0] merge(logic [`LINE_WIDTH-1:0] line,
		logic [`SCALAR_WIDTH-1:0] data, logic [1:0] dt, logic [1:0] sz, logic [4:0] off);
		int bits;
		int pos;
		bits = lane_bits(dt, sz);
		pos = (int'(off) / (bits / 8)) * bits;
		if (dt == reserved)
			return '0;
		return (line & ~(256'(low_mask(bits)) << pos)) | (256'(data & low_mask(bits)) << pos);
	endfunction

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `LINE_COUNT; i++)
				model[i] = '0;
			expect_q.delete();
			cycle_q.delete();
			test_q.delete();
			cycle = 0;
			mismatch_count = 0;
			protocol_count = 0;
		end
		else
		begin
			cycle++;
			if (rd_valid && expect_q.size() == 0)
			begin
				$display("error: rd_valid at cycle %0d with no read pending", cycle);
				protocol_count++;
			end
			else if (rd_valid)
			begin
				exp_data = expect_q.pop_front();
				exp_cycle = cycle_q.pop_front();
				exp_test = test_q.pop_front();
				if (rd_data !== exp_data)
				begin
					$display("mismatch %s: expected %h, actual %h", names[exp_test],
						exp_data, rd_data);
					mismatch_count++;
				end
				if (cycle - exp_cycle != 3)
				begin
					$display("mismatch %s latency: expected 3, actual %0d", names[exp_test],
						cycle - exp_cycle);
					mismatch_count++;
				end
			end
			// read older than its latency was lost
			if (cycle_q.size() != 0 && cycle - cycle_q[0] > 3)
			begin
				$display("error: read issued at cycle %0d never got rd_valid", cycle_q[0]);
				protocol_count++;
				void'(expect_q.pop_front());
				void'(cycle_q.pop_front());
				void'(test_q.pop_front());
			end
			if (cmd_valid && cmd_word[11])
				model[cmd_word[10:9]] = merge(model[cmd_word[10:9]], wr_data,
					cmd_word[8:7], cmd_word[6:5], cmd_word[4:0]);
			else if (cmd_valid)
			begin
				expect_q.push_back(predict(model[cmd_word[10:9]], cmd_word[8:7],
					cmd_word[6:5], cmd_word[4:0]));
				cycle_q.push_back(cycle);
				test_q.push_back(int'(test_id));
			end
		end
		pending = expect_q.size();
	end

endmodule

// ==== bench/tb_scalar_access.sv ====
`timescale 1ns/100ps
`include "scalar_access_defines.svh"

module tb_scalar_access
	import scalar_cpu_pkg::*;
();

	logic clk;
	logic rst_n;
	logic cmd_valid;
	logic [`CMD_WIDTH-1:0] cmd_word;
	logic [`SCALAR_WIDTH-1:0] wr_data;
	logic rd_valid;
	logic [`SCALAR_WIDTH-1:0] rd_data;
	logic [2:0] test_id;
	logic [`SCALAR_WIDTH-1:0] pattern;
	logic [`CMD_WIDTH-1:0] rand_word;
	int mismatch_count;
	int protocol_count;
	int pending;
	int timeout_count;
	int seed;

	scalar_access_top u_scalar_access_top
	(
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_word(cmd_word),
		.wr_data(wr_data),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	scalar_access_checker u_checker
	(
		.clk(clk),
		.rst_n(rst_n),
		.test_id(test_id),
		.cmd_valid(cmd_valid),
		.cmd_word(cmd_word),
		.wr_data(wr_data),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.mismatch_count(mismatch_count),
		.protocol_count(protocol_count),
		.pending(pending)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic issue(input logic wr, input logic [1:0] line, input logic [1:0] dt,
		input logic [1:0] sz, input logic [4:0] off, input logic [`SCALAR_WIDTH-1:0] data);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_word <= {wr, line, dt, sz, off};
		wr_data <= data;
	endtask

	task automatic idle();
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	// let outstanding reads come back
	task automatic drain();
		int waited;
		idle();
		waited = 0;
		@(negedge clk);
		while (pending != 0 && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		if (pending != 0)
		begin
			$display("timeout: %0d reads still pending after %0d cycles", pending, waited);
			timeout_count++;
		end
	endtask

	initial
	begin
		seed = 80;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_word = '0;
		wr_data = '0;
		test_id = 3'd0;
		timeout_count = 0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		for (int l = 0; l < 4; l++)
			for (int dt = 0; dt < 4; dt++)
				for (int sz = 0; sz < 4; sz++)
					issue(1'b0, 2'(l), 2'(dt), 2'(sz), 5'(l * 8 + sz * 2), '0);
		drain();

		// every size at every offset, read back as signed or unsigned
		test_id = 3'd1;
		for (int sz = 0; sz < 4; sz++)
			for (int off = 0; off < 32; off++)
			begin
				pattern = {$random(seed), $random(seed)};
				issue(1'b1, 2'(off), unsgn_int, 2'(sz), 5'(off), pattern);
				issue(1'b0, 2'(off), 2'(off % 2), 2'(sz), 5'(off), '0);
			end
		drain();

		test_id = 3'd2;
		for (int sz = 0; sz < 4; sz++)
		begin
			pattern = {$random(seed), $random(seed)};
			issue(1'b1, 2'd2, unsgn_int, 2'(sz), 5'($random(seed)), pattern);
			for (int l = 0; l < 4; l++)
				for (int q = 0; q < 4; q++)
					issue(1'b0, 2'(l), unsgn_int, size_64, 5'(q * 8), '0);
		end
		drain();

		// top bit of every lane size set
		test_id = 3'd3;
		pattern = {$random(seed), $random(seed)} | 64'h8000_0000_8000_8080;
		for (int q = 0; q < 4; q++)
			issue(1'b1, 2'd3, unsgn_int, size_64, 5'(q * 8), pattern);
		for (int sz = 0; sz < 4; sz++)
			for (int dt = 0; dt < 3; dt++)
				issue(1'b0, 2'd3, 2'(dt), 2'(sz), 5'(sz * 8), '0);
		drain();

		test_id = 3'd4;
		for (int sz = 0; sz < 4; sz++)
			issue(1'b0, 2'd3, reserved, 2'(sz), 5'(sz * 8), '0);
		issue(1'b1, 2'd3, reserved, size_8, 5'd5, '1);
		for (int q = 0; q < 4; q++)
			issue(1'b0, 2'd3, unsgn_int, size_64, 5'(q * 8), '0);
		drain();

		test_id = 3'd5;
		for (int i = 0; i < 32; i++)
		begin
			pattern = {$random(seed), $random(seed)};
			issue(1'b1, 2'(i), sgn_int, 2'(i / 8), 5'(i), pattern);
			issue(1'b0, 2'(i), sgn_int, 2'(i / 8), 5'(i), '0);
		end
		drain();

		test_id = 3'd6;
		for (int i = 0; i < 600; i++)
		begin
			rand_word = 12'($random(seed));
			pattern = {$random(seed), $random(seed)};
			if ($random(seed) % 4 == 0)
				idle();
			else
				issue(rand_word[11], rand_word[10:9], rand_word[8:7], rand_word[6:5],
					rand_word[4:0], pattern);
		end
		drain();

		$display("errors: mismatches=%0d protocol=%0d timeouts=%0d", mismatch_count,
			protocol_count, timeout_count);
		if (mismatch_count == 0 && protocol_count == 0 && timeout_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/scalar_cpu_pkg.sv
rtl/scalar_shifter_pkg.sv
rtl/scalar_stage_if.sv
rtl/scalar_decode.sv
rtl/scalar_data_shifter.sv
rtl/scalar_execute.sv
rtl/scalar_result.sv
rtl/scalar_access_top.sv
bench/scalar_access_assertions.sv
bench/scalar_access_checker.sv
bench/tb_scalar_access.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the scalar access testbench with Verilator

verilator --binary --timing --assert -f sim.f --top-module tb_scalar_access -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_scalar_access)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q -F '*** TEST PASSED ***'; then
	exit 0
fi
exit 1
